//--- hdc_core_top.f
+incdir+include
hw/hdc_pkg.sv
hw/im_bus_if.sv
hw/hold_fifo.sv
hw/item_memory.sv
hw/im_arbiter.sv
hw/im_fetch_port.sv
hw/hv_encoder.sv
hw/hdc_core_top.sv
tb/hdc_core_assertions.sv
tb/hdc_core_tb.sv

//--- tb/hdc_core_tb.sv
//----------------------------------------------------------
// HDC core testbench
// Random address pairs on both streams, checked against a
// queue model of item lookup, XOR binding and majority
//----------------------------------------------------------
`default_nettype none

`include "hdc_defs.svh"

module hdc_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_JOBS        = 40;
  localparam int MAX_ITEMS       = 30;
  localparam int FILL_JOB        = 20;
  localparam int WATCHDOG_CYCLES = (NUM_JOBS + 1) * MAX_ITEMS * 20 + 1000;

  logic               clk = 1'b0;
  logic               arst_n;
  logic               start;
  hdc_pkg::bund_cnt_t num_items;
  logic               busy;
  hdc_pkg::im_addr_t  a_data;
  logic               a_valid;
  logic               a_ready;
  hdc_pkg::im_addr_t  b_data;
  logic               b_valid;
  logic               b_ready;
  hdc_pkg::hv_t       qhv;
  logic               qhv_valid;
  logic               qhv_ready;

  integer             seed = 70;

  // Accepted addresses per stream, oldest first
  hdc_pkg::im_addr_t  sent_q [2][$];
  // Stimulus of the current job
  hdc_pkg::im_addr_t  job_addr [2][MAX_ITEMS];
  int                 job_gap [2][MAX_ITEMS];
  int                 job_skew [2];

  hdc_core_top uut (
    .clk_i            ( clk       ),
    .arst_n_i         ( arst_n    ),
    .start_i          ( start     ),
    .num_items_i      ( num_items ),
    .busy_o           ( busy      ),
    .lowdim_a_data_i  ( a_data    ),
    .lowdim_a_valid_i ( a_valid   ),
    .lowdim_a_ready_o ( a_ready   ),
    .lowdim_b_data_i  ( b_data    ),
    .lowdim_b_valid_i ( b_valid   ),
    .lowdim_b_ready_o ( b_ready   ),
    .qhv_o            ( qhv       ),
    .qhv_valid_o      ( qhv_valid ),
    .qhv_ready_i      ( qhv_ready )
  );

  always #50 clk = ~clk;

  //----------------------------------------------------------
  // Helpers and reference model
  //----------------------------------------------------------
  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_hv(input string name, input hdc_pkg::hv_t exp, input hdc_pkg::hv_t got);
    if (got !== exp) begin
      $display("error %0t %s expected %h got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("error %0t %s expected %b got %b", $time, name, exp, got);
      stop_run();
    end
  endtask

  // Inputs change 5 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  function automatic int rand_below(input int m);
    return int'($unsigned($random(seed)) % m);
  endfunction

  // Seed rotated left one bit at a time
  function automatic hdc_pkg::hv_t model_item(input int k);
    hdc_pkg::hv_t v;
    v = `HDC_IM_SEED;
    repeat (k * `HDC_IM_ROT_STEP) v = {v[`HDC_HV_DIM-2:0], v[`HDC_HV_DIM-1]};
    return v;
  endfunction

  task automatic model_query(input int n, output hdc_pkg::hv_t exp);
    int           cnt [`HDC_HV_DIM];
    hdc_pkg::hv_t bound;
    if (sent_q[0].size() < n || sent_q[1].size() < n) begin
      $display("model holds fewer addresses than the job needs");
      stop_run();
    end
    cnt = '{default: 0};
    for (int p = 0; p < n; p++) begin
      bound = model_item(sent_q[0].pop_front()) ^ model_item(sent_q[1].pop_front());
      for (int i = 0; i < `HDC_HV_DIM; i++) begin
        cnt[i] += int'(bound[i]);
      end
    end
    // Ties go to 0
    for (int i = 0; i < `HDC_HV_DIM; i++) begin
      exp[i] = (2 * cnt[i] > n);
    end
  endtask

  //----------------------------------------------------------
  // Stimulus and result collection
  //----------------------------------------------------------
  task automatic prepare_job(input int n, input bit gaps_on, input bit skew_on);
    for (int s = 0; s < 2; s++) begin
      job_skew[s] = 0;
      for (int i = 0; i < n; i++) begin
        job_addr[s][i] = hdc_pkg::im_addr_t'(rand_below(`HDC_NUM_ITEMS));
        job_gap[s][i]  = gaps_on ? rand_below(4) : 0;
      end
    end
    if (skew_on) begin
      job_skew[rand_below(2)] = 10 + rand_below(40);
    end
  endtask

  task automatic push_addr(input int side, input hdc_pkg::im_addr_t addr);
    logic ok;
    if (side == 0) begin
      a_valid = 1'b1;
      a_data  = addr;
    end else begin
      b_valid = 1'b1;
      b_data  = addr;
    end
    do begin
      ok = (side == 0) ? a_ready : b_ready;
      tick();
    end while (!ok);
    sent_q[side].push_back(addr);
    if (side == 0) begin
      a_valid = 1'b0;
    end else begin
      b_valid = 1'b0;
    end
  endtask

  task automatic drive_stream(input int side, input int n);
    repeat (job_skew[side]) tick();
    for (int i = 0; i < n; i++) begin
      push_addr(side, job_addr[side][i]);
      repeat (job_gap[side][i]) tick();
    end
  endtask

  // Extra addresses while the result is held, until ready drops
  task automatic fill_until_full(input int side);
    int sent;
    sent = 0;
    while (((side == 0) ? a_ready : b_ready) && sent < 12) begin
      push_addr(side, hdc_pkg::im_addr_t'(rand_below(`HDC_NUM_ITEMS)));
      sent++;
    end
    if ((side == 0) ? a_ready : b_ready) begin
      $display("lowdim ready of stream %0d never dropped while the query was held", side);
      stop_run();
    end
  endtask

  task automatic start_job(input int n);
    num_items = hdc_pkg::bund_cnt_t'(n);
    start     = 1'b1;
    tick();
    start     = 1'b0;
    check_bit("busy_o", 1'b1, busy);
  endtask

  task automatic collect_result(input int n, input int hold);
    hdc_pkg::hv_t exp;
    while (!qhv_valid) tick();
    check_bit("busy_o", 1'b1, busy);
    model_query(n, exp);
    check_hv("qhv_o", exp, qhv);
    repeat (hold) begin
      tick();
      check_bit("qhv_valid_o", 1'b1, qhv_valid);
      check_hv("qhv_o", exp, qhv);
    end
    qhv_ready = 1'b1;
    tick();
    qhv_ready = 1'b0;
    check_bit("qhv_valid_o", 1'b0, qhv_valid);
    check_bit("busy_o", 1'b0, busy);
  endtask

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    int n;
    int hold;
    arst_n    = 1'b0;
    start     = 1'b0;
    num_items = '0;
    a_data    = '0;
    a_valid   = 1'b0;
    b_data    = '0;
    b_valid   = 1'b0;
    qhv_ready = 1'b0;
    repeat (3) @(posedge clk);
    #5;
    arst_n = 1'b1;

    check_bit("qhv_valid_o", 1'b0, qhv_valid);
    check_bit("busy_o", 1'b0, busy);
    check_bit("lowdim_a_ready_o", 1'b1, a_ready);
    check_bit("lowdim_b_ready_o", 1'b1, b_ready);

    // Single pair gives item[a] ^ item[b]
    prepare_job(1, 1'b0, 1'b0);
    start_job(1);
    fork
      drive_stream(0, 1);
      drive_stream(1, 1);
      collect_result(1, 0);
    join

    for (int job = 0; job < NUM_JOBS; job++) begin
      n = 1 + rand_below(MAX_ITEMS);
      prepare_job(n, job >= 10, job >= 10 && job % 3 == 0);
      hold = (job >= 20) ? rand_below(8) : 0;
      start_job(n);
      if (job == FILL_JOB) begin
        fork
          drive_stream(0, n);
          drive_stream(1, n);
        join
        while (!qhv_valid) tick();
        fill_until_full(0);
        fill_until_full(1);
        collect_result(n, 2);
      end else begin
        fork
          drive_stream(0, n);
          drive_stream(1, n);
          collect_result(n, hold);
        join
      end
    end

    if (uut.u_core_chk.err_cnt != 0) begin
      $display("concurrent assertions failed during the run");
      stop_run();
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  // Stop at the first assertion failure
  always @(negedge clk) begin
    if (uut.u_core_chk.err_cnt != 0) begin
      $display("concurrent assertion failed at %0t", $time);
      stop_run();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
    stop_run();
  end

endmodule

`default_nettype wire

//--- tb/hdc_core_assertions.sv
//----------------------------------------------------------
// HDC core assertions
// Grant exclusivity, response timing and query hold checks
// on the arbiter buses and the encoder output
//----------------------------------------------------------
`default_nettype none

module hdc_core_assertions (
  input wire logic         clk_i,
  input wire logic         arst_n_i,
  input wire logic         gnt_a_i,
  input wire logic         gnt_b_i,
  input wire logic         rsp_valid_a_i,
  input wire logic         rsp_valid_b_i,
  input wire hdc_pkg::hv_t qhv_i,
  input wire logic         qhv_valid_i,
  input wire logic         qhv_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failure count, watched by the testbench
  int err_cnt = 0;

  // One memory read per cycle
  gnt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(gnt_a_i && gnt_b_i))
    else begin
      $error("both ports granted in the same cycle");
      err_cnt++;
    end

  // Response exactly one cycle after the grant
  rsp_a_timing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_a_i == $past(gnt_a_i))
    else begin
      $error("port A response not one cycle after its grant");
      err_cnt++;
    end

  rsp_b_timing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_b_i == $past(gnt_b_i))
    else begin
      $error("port B response not one cycle after its grant");
      err_cnt++;
    end

  // Pending query stays put
  qhv_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    qhv_valid_i && !qhv_ready_i |=> qhv_valid_i && $stable(qhv_i))
    else begin
      $error("query changed while waiting for ready");
      err_cnt++;
    end

endmodule

bind hdc_core_top hdc_core_assertions u_core_chk (
  .clk_i         ( clk_i           ),
  .arst_n_i      ( arst_n_i        ),
  .gnt_a_i       ( bus_a.gnt       ),
  .gnt_b_i       ( bus_b.gnt       ),
  .rsp_valid_a_i ( bus_a.rsp_valid ),
  .rsp_valid_b_i ( bus_b.rsp_valid ),
  .qhv_i         ( qhv_o           ),
  .qhv_valid_i   ( qhv_valid_o     ),
  .qhv_ready_i   ( qhv_ready_i     )
);

`default_nettype wire

//--- hw/hdc_core_top.sv
//----------------------------------------------------------
// HDC core top
// Two address streams share one item memory, the encoder
// bundles bound pairs into a query hypervector
//----------------------------------------------------------
`default_nettype none

module hdc_core_top (
  // Clock and reset
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  // Job control
  input  wire logic               start_i,
  input  wire hdc_pkg::bund_cnt_t num_items_i,
  output logic                    busy_o,
  // Address streams
  input  wire hdc_pkg::im_addr_t  lowdim_a_data_i,
  input  wire logic               lowdim_a_valid_i,
  output logic                    lowdim_a_ready_o,
  input  wire hdc_pkg::im_addr_t  lowdim_b_data_i,
  input  wire logic               lowdim_b_valid_i,
  output logic                    lowdim_b_ready_o,
  // Query output
  output hdc_pkg::hv_t            qhv_o,
  output logic                    qhv_valid_o,
  input  wire logic               qhv_ready_i
);

  //----------------------------------------------------------
  // Internal wiring
  //----------------------------------------------------------
  im_bus_if bus_a ();
  im_bus_if bus_b ();

  logic              rd_en;
  hdc_pkg::im_addr_t rd_addr;
  hdc_pkg::hv_t      rd_data;

  hdc_pkg::hv_t      hv_a;
  hdc_pkg::hv_t      hv_b;
  logic              hv_a_valid;
  logic              hv_b_valid;
  logic              pop_a;
  logic              pop_b;

  //----------------------------------------------------------
  // Fetch ports
  //----------------------------------------------------------
  im_fetch_port u_fetch_a (
    .clk_i        ( clk_i            ),
    .arst_n_i     ( arst_n_i         ),
    .addr_i       ( lowdim_a_data_i  ),
    .addr_valid_i ( lowdim_a_valid_i ),
    .addr_ready_o ( lowdim_a_ready_o ),
    .bus          ( bus_a            ),
    .hv_o         ( hv_a             ),
    .hv_valid_o   ( hv_a_valid       ),
    .pop_i        ( pop_a            )
  );

  im_fetch_port u_fetch_b (
    .clk_i        ( clk_i            ),
    .arst_n_i     ( arst_n_i         ),
    .addr_i       ( lowdim_b_data_i  ),
    .addr_valid_i ( lowdim_b_valid_i ),
    .addr_ready_o ( lowdim_b_ready_o ),
    .bus          ( bus_b            ),
    .hv_o         ( hv_b             ),
    .hv_valid_o   ( hv_b_valid       ),
    .pop_i        ( pop_b            )
  );

  // Shared memory behind the arbiter
  im_arbiter u_arbiter (
    .clk_i     ( clk_i    ),
    .arst_n_i  ( arst_n_i ),
    .bus_a     ( bus_a    ),
    .bus_b     ( bus_b    ),
    .rd_en_o   ( rd_en    ),
    .rd_addr_o ( rd_addr  ),
    .rd_data_i ( rd_data  )
  );

  item_memory u_item_memory (
    .clk_i     ( clk_i    ),
    .arst_n_i  ( arst_n_i ),
    .rd_en_i   ( rd_en    ),
    .rd_addr_i ( rd_addr  ),
    .rd_data_o ( rd_data  )
  );

  //----------------------------------------------------------
  // Encoder
  //----------------------------------------------------------
  hv_encoder u_encoder (
    .clk_i        ( clk_i       ),
    .arst_n_i     ( arst_n_i    ),
    .start_i      ( start_i     ),
    .num_items_i  ( num_items_i ),
    .hv_a_i       ( hv_a        ),
    .hv_b_i       ( hv_b        ),
    .hv_a_valid_i ( hv_a_valid  ),
    .hv_b_valid_i ( hv_b_valid  ),
    .pop_a_o      ( pop_a       ),
    .pop_b_o      ( pop_b       ),
    .qhv_o        ( qhv_o       ),
    .qhv_valid_o  ( qhv_valid_o ),
    .qhv_ready_i  ( qhv_ready_i ),
    .busy_o       ( busy_o      )
  );

endmodule

`default_nettype wire

//--- hw/hv_encoder.sv
//----------------------------------------------------------
// Hypervector encoder
// Binds A and B by XOR, bundles with one counter per bit and
// thresholds by majority into the query hypervector
//----------------------------------------------------------
`default_nettype none

`include "hdc_defs.svh"

module hv_encoder (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  wire logic               start_i,
  input  wire hdc_pkg::bund_cnt_t num_items_i,
  input  wire hdc_pkg::hv_t       hv_a_i,
  input  wire hdc_pkg::hv_t       hv_b_i,
  input  wire logic               hv_a_valid_i,
  input  wire logic               hv_b_valid_i,
  output logic                    pop_a_o,
  output logic                    pop_b_o,
  output hdc_pkg::hv_t            qhv_o,
  output logic                    qhv_valid_o,
  input  wire logic               qhv_ready_i,
  output logic                    busy_o
);

  hdc_pkg::bund_cnt_t cnt_q [`HDC_HV_DIM];
  hdc_pkg::bund_cnt_t cnt_d [`HDC_HV_DIM];
  hdc_pkg::bund_cnt_t target_q;
  hdc_pkg::bund_cnt_t pair_cnt_q;
  hdc_pkg::hv_t       bound;
  hdc_pkg::hv_t       qhv_d;
  hdc_pkg::hv_t       qhv_q;
  logic               busy_q;
  logic               qhv_valid_q;
  logic               consume;
  logic               last_pair;

  // One pair per cycle, nothing while a result waits
  assign consume   = busy_q && !qhv_valid_q && hv_a_valid_i && hv_b_valid_i;
  assign last_pair = consume && (pair_cnt_q == target_q - 1'b1);
  assign pop_a_o   = consume;
  assign pop_b_o   = consume;

  //----------------------------------------------------------
  // Bind, bundle and threshold
  //----------------------------------------------------------
  assign bound = hv_a_i ^ hv_b_i;

  always_comb begin
    for (int i = 0; i < `HDC_HV_DIM; i++) begin
      cnt_d[i] = cnt_q[i] + hdc_pkg::bund_cnt_t'(bound[i]);
      // Strict majority, so a tie gives 0
      qhv_d[i] = {cnt_d[i], 1'b0} > {1'b0, target_q};
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      cnt_q <= '{default: '0};
    end else if (consume) begin
      cnt_q <= cnt_d;
    end
    if (last_pair) begin
      qhv_q <= qhv_d;
    end
  end

  //----------------------------------------------------------
  // Control
  //----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      qhv_valid_q <= 1'b0;
      target_q    <= '0;
      pair_cnt_q  <= '0;
    end else if (start_i) begin
      busy_q      <= 1'b1;
      qhv_valid_q <= 1'b0;
      target_q    <= num_items_i;
      pair_cnt_q  <= '0;
    end else begin
      if (consume) begin
        pair_cnt_q <= pair_cnt_q + 1'b1;
      end
      if (last_pair) begin
        qhv_valid_q <= 1'b1;
      end else if (qhv_valid_q && qhv_ready_i) begin
        // Result taken, job done
        qhv_valid_q <= 1'b0;
        busy_q      <= 1'b0;
      end
    end
  end

  assign qhv_o       = qhv_q;
  assign qhv_valid_o = qhv_valid_q;
  assign busy_o      = busy_q;

endmodule

`default_nettype wire

//--- hw/im_fetch_port.sv
//----------------------------------------------------------
// Item memory fetch port
// Queues addresses of one stream, requests the shared item
// memory and buffers the returned hypervectors
//----------------------------------------------------------
`default_nettype none

`include "hdc_defs.svh"

module im_fetch_port (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire hdc_pkg::im_addr_t addr_i,
  input  wire logic              addr_valid_i,
  output logic                   addr_ready_o,
  im_bus_if.requester            bus,
  output hdc_pkg::hv_t           hv_o,
  output logic                   hv_valid_o,
  input  wire logic              pop_i
);

  localparam int unsigned HOLD_CNT_W = $clog2(`HDC_HOLD_FIFO_DEPTH + 1);

  logic                  addr_full;
  logic                  addr_empty;
  logic                  hold_empty;
  logic [HOLD_CNT_W-1:0] hold_free;
  logic [HOLD_CNT_W-1:0] inflight_q;
  logic                  issue;

  assign addr_ready_o = !addr_full;

  hold_fifo #(
    .T     ( hdc_pkg::im_addr_t   ),
    .DEPTH ( `HDC_ADDR_FIFO_DEPTH )
  ) u_addr_fifo (
    .clk_i    ( clk_i                       ),
    .arst_n_i ( arst_n_i                    ),
    .push_i   ( addr_valid_i && !addr_full  ),
    .data_i   ( addr_i                      ),
    .pop_i    ( issue                       ),
    .data_o   ( bus.addr                    ),
    .empty_o  ( addr_empty                  ),
    .full_o   ( addr_full                   ),
    .free_o   (                             )
  );

  // Only ask when a hold slot is left for every read in flight
  assign bus.req = !addr_empty && (inflight_q < hold_free);
  assign issue   = bus.req && bus.gnt;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inflight_q <= '0;
    end else begin
      case ({issue, bus.rsp_valid})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  hold_fifo #(
    .T     ( hdc_pkg::hv_t        ),
    .DEPTH ( `HDC_HOLD_FIFO_DEPTH )
  ) u_hold_fifo (
    .clk_i    ( clk_i         ),
    .arst_n_i ( arst_n_i      ),
    .push_i   ( bus.rsp_valid ),
    .data_i   ( bus.rsp_hv    ),
    .pop_i    ( pop_i         ),
    .data_o   ( hv_o          ),
    .empty_o  ( hold_empty    ),
    .full_o   (               ),
    .free_o   ( hold_free     )
  );

  assign hv_valid_o = !hold_empty;

endmodule

`default_nettype wire

//--- hw/im_arbiter.sv
//----------------------------------------------------------
// Item memory arbiter
// Round-robin grant of the single memory port to one of two
// fetch ports, read data routed back one cycle later
//----------------------------------------------------------
`default_nettype none

module im_arbiter (
  input  wire logic         clk_i,
  input  wire logic         arst_n_i,
  im_bus_if.arbiter         bus_a,
  im_bus_if.arbiter         bus_b,
  output logic              rd_en_o,
  output hdc_pkg::im_addr_t rd_addr_o,
  input  wire hdc_pkg::hv_t rd_data_i
);

  hdc_pkg::port_id_e last_gnt_q;
  logic              rsp_valid_q;
  logic              gnt_a;
  logic              gnt_b;

  //----------------------------------------------------------
  // Grant, same cycle as the request
  //----------------------------------------------------------
  always_comb begin
    gnt_a = 1'b0;
    gnt_b = 1'b0;
    if (bus_a.req && bus_b.req) begin
      // Contention goes to whoever lost last time
      if (last_gnt_q == hdc_pkg::PORT_A) begin
        gnt_b = 1'b1;
      end else begin
        gnt_a = 1'b1;
      end
    end else begin
      gnt_a = bus_a.req;
      gnt_b = bus_b.req;
    end
  end

  assign bus_a.gnt = gnt_a;
  assign bus_b.gnt = gnt_b;

  assign rd_en_o   = gnt_a || gnt_b;
  assign rd_addr_o = gnt_b ? bus_b.addr : bus_a.addr;

  //----------------------------------------------------------
  // Last grant, which is also the owner of the read in flight
  //----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_gnt_q  <= hdc_pkg::PORT_B;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_en_o;
      if (rd_en_o) begin
        last_gnt_q <= gnt_b ? hdc_pkg::PORT_B : hdc_pkg::PORT_A;
      end
    end
  end

  // Data goes to both, only the owner sees valid
  assign bus_a.rsp_valid = rsp_valid_q && (last_gnt_q == hdc_pkg::PORT_A);
  assign bus_b.rsp_valid = rsp_valid_q && (last_gnt_q == hdc_pkg::PORT_B);
  assign bus_a.rsp_hv    = rd_data_i;
  assign bus_b.rsp_hv    = rd_data_i;

endmodule

`default_nettype wire

//--- hw/item_memory.sv
//----------------------------------------------------------
// Item memory
// Single-ported table of seed-derived hypervectors with a
// registered read port
//----------------------------------------------------------
`default_nettype none

`include "hdc_defs.svh"

module item_memory (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              rd_en_i,
  input  wire hdc_pkg::im_addr_t rd_addr_i,
  output hdc_pkg::hv_t           rd_data_o
);

  // Rotate left, amount taken modulo the vector width
  function automatic hdc_pkg::hv_t rotl_hv(input hdc_pkg::hv_t v, input int unsigned amt);
    int unsigned s;
    s = amt % `HDC_HV_DIM;
    return (v << s) | (v >> (`HDC_HV_DIM - s));
  endfunction

  hdc_pkg::hv_t im_table [`HDC_NUM_ITEMS];

  // Table is fixed at elaboration
  for (genvar k = 0; k < `HDC_NUM_ITEMS; k++) begin : g_item
    assign im_table[k] = rotl_hv(`HDC_IM_SEED, k * `HDC_IM_ROT_STEP);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_data_o <= '0;
    end else if (rd_en_i) begin
      rd_data_o <= im_table[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

//--- hw/hold_fifo.sv
//----------------------------------------------------------
// Hold FIFO
// Small synchronous circular buffer for any payload type,
// head visible on data_o with no read latency
//----------------------------------------------------------
`default_nettype none

module hold_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2,
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  input  wire logic             push_i,
  input  wire T                 data_i,
  input  wire logic             pop_i,
  output T                      data_o,
  output logic                  empty_o,
  output logic                  full_o,
  output logic [CNT_W-1:0]      free_o
);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign free_o  = CNT_W'(DEPTH) - count_q;
  assign data_o  = mem_q[rd_ptr_q];

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/im_bus_if.sv
//----------------------------------------------------------
// Item memory bus
// Request and response path between one fetch port and the
// item memory arbiter
//----------------------------------------------------------
`default_nettype none

interface im_bus_if;

  // Request side
  logic              req;
  hdc_pkg::im_addr_t addr;
  logic              gnt;

  // Response one cycle after the grant
  logic              rsp_valid;
  hdc_pkg::hv_t      rsp_hv;

  modport requester (
    output req, addr,
    input  gnt, rsp_valid, rsp_hv
  );

  modport arbiter (
    input  req, addr,
    output gnt, rsp_valid, rsp_hv
  );

endinterface

`default_nettype wire

//--- hw/hdc_pkg.sv
//----------------------------------------------------------
// HDC core package
// Shared types for hypervectors, item addresses, counters
// and arbiter requester ids
//----------------------------------------------------------
`default_nettype none

`include "hdc_defs.svh"

package hdc_pkg;

  // One full hypervector
  typedef logic [`HDC_HV_DIM-1:0] hv_t;

  // Item memory address
  typedef logic [`HDC_IM_ADDR_W-1:0] im_addr_t;

  // Bundling counter, also used for pair counts
  typedef logic [`HDC_BUND_CNT_W-1:0] bund_cnt_t;

  // Requesters of the shared item memory
  typedef enum logic {
    PORT_A = 1'b0,
    PORT_B = 1'b1
  } port_id_e;

endpackage

`default_nettype wire

//--- include/hdc_defs.svh
//----------------------------------------------------------
// HDC core constants
// Hypervector size, item memory geometry, queue depths and
// the seed rule that fills the item memory
//----------------------------------------------------------
`ifndef HDC_DEFS_SVH
`define HDC_DEFS_SVH

//----------------------------------------------------------
// Dimensions
//----------------------------------------------------------
`define HDC_HV_DIM          64
`define HDC_NUM_ITEMS       16
`define HDC_IM_ADDR_W       4

//----------------------------------------------------------
// Queue depths per fetch port
//----------------------------------------------------------
`define HDC_ADDR_FIFO_DEPTH 4
`define HDC_HOLD_FIFO_DEPTH 2

// Bundling counter and pair count width
`define HDC_BUND_CNT_W      8

//----------------------------------------------------------
// Item memory seed
//----------------------------------------------------------
// Item k is the seed rotated left by k * step bits
`define HDC_IM_SEED         64'h9E37_79B9_7F4A_7C15
`define HDC_IM_ROT_STEP     4

`endif
